// ==== filelist.f ====
verilog/glb_pkg.sv
verilog/glb_bank.sv
verilog/glb_port_map.sv
verilog/glb_bank_arb.sv
verilog/glb_wr_port.sv
verilog/glb_rd_port.sv
verilog/glb_top.sv
test/glb_tb.sv

// ==== Bender.yml ====
package:
  name: glb

sources:
  - files:
      - verilog/glb_pkg.sv
      - verilog/glb_bank.sv
      - verilog/glb_port_map.sv
      - verilog/glb_bank_arb.sv
      - verilog/glb_wr_port.sv
      - verilog/glb_rd_port.sv
      - verilog/glb_top.sv
  - target: test
    files:
      - test/glb_tb.sv

// ==== test/glb_tb.sv ====
// ==================================================
// Global buffer testbench
// Random traffic on two write/read pairs against a
// FIFO model, back-pressure, full and count checks
// ==================================================

`timescale 1ns/1ns

module glb_tb;

    // Pair 0 on banks 0-3 with two lanes, pair 1 on banks 4-7 with one lane
    localparam int unsigned NUM0 = 100;
    localparam int unsigned NUM1 = 150;
    localparam int unsigned PAR0 = 2;
    localparam int unsigned PAR1 = 1;
    // Capacity is rows per bank times banks, divided by lanes
    localparam int unsigned CAP0 = 16 * 4 / PAR0;
    localparam int unsigned CAP1 = 16 * 4 / PAR1;
    localparam int unsigned TIMEOUT_CYC = 4 * (NUM0 + NUM1) + 200;

    logic                clk;
    logic                rst_n;
    logic [3:0]          cfg_vld;
    glb_pkg::port_cfg_t  cfg [4];
    logic [3:0]          cfg_rdy;
    logic [1:0]          wr_vld;
    glb_pkg::lanes_t     wr_dat [2];
    logic [1:0]          wr_rdy;
    glb_pkg::addr_t      wr_addr [2];
    logic [1:0]          rd_vld;
    glb_pkg::lanes_t     rd_dat [2];
    logic [1:0]          rd_rdy;
    glb_pkg::addr_t      rd_addr [2];

    // Model state per pair
    int unsigned     num_p [2];
    int unsigned     par_p [2];
    int unsigned     cap_p [2];
    int unsigned     wcnt [2];
    int unsigned     rcnt [2];
    int unsigned     popped [2];
    int unsigned     fill_max [2];
    int unsigned     holds [2];
    logic            mvld [2];
    logic            hold_q [2];
    glb_pkg::lanes_t hold_dat [2];
    glb_pkg::lanes_t exp_q [2][$];

    int unsigned errors;
    int unsigned checks;
    int unsigned cycle;
    int unsigned err_start;
    logic        mon_on;

    glb_top #(
        .NUM_WRPORT (2),
        .NUM_RDPORT (2)
    ) DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_vld_i (cfg_vld),
        .cfg_i     (cfg),
        .cfg_rdy_o (cfg_rdy),
        .wr_vld_i  (wr_vld),
        .wr_dat_i  (wr_dat),
        .wr_rdy_o  (wr_rdy),
        .wr_addr_o (wr_addr),
        .rd_vld_o  (rd_vld),
        .rd_dat_o  (rd_dat),
        .rd_rdy_i  (rd_rdy),
        .rd_addr_o (rd_addr)
    );

    always #2 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= TIMEOUT_CYC) begin
            $display("Timeout after %0d cycles, traffic did not complete", cycle);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input int n, input string name);
        $display("[test %0d] %s: %0d errors", n, name, errors - err_start);
        err_start = errors;
    endtask

    // ==================================================
    // Model step at the falling edge
    // ==================================================
    task automatic step_pair(input int p);
        glb_pkg::lanes_t masked;
        glb_pkg::lanes_t front;
        int unsigned     fill;
        int              dut_fill;
        logic            exp_rdy;
        logic            exp_issue;
        fill      = wcnt[p] - rcnt[p];
        dut_fill  = int'(wr_addr[p]) - int'(rd_addr[p]);
        exp_rdy   = (wcnt[p] < num_p[p]) && (fill < cap_p[p]);
        exp_issue = (rcnt[p] < num_p[p]) && (rcnt[p] < wcnt[p]) && (!mvld[p] || rd_rdy[p]);
        compare($sformatf("wr_rdy_o[%0d]", p), wr_rdy[p], exp_rdy);
        compare($sformatf("rd_vld_o[%0d]", p), rd_vld[p], mvld[p]);
        compare($sformatf("wr_addr_o[%0d]", p), wr_addr[p], wcnt[p]);
        compare($sformatf("rd_addr_o[%0d]", p), rd_addr[p], rcnt[p]);
        // Unread words held by the DUT stay within capacity
        compare($sformatf("fill_in_range[%0d]", p),
                (dut_fill >= 0) && (dut_fill <= int'(cap_p[p])), 1'b1);
        if (fill == cap_p[p]) begin
            compare($sformatf("wr_rdy_o_full[%0d]", p), wr_rdy[p], 1'b0);
        end
        if (fill > fill_max[p]) begin
            fill_max[p] = fill;
        end
        // Output must not move while stalled
        if (hold_q[p]) begin
            compare($sformatf("rd_dat_o_hold[%0d]", p), rd_dat[p], hold_dat[p]);
        end
        hold_q[p]   = mvld[p] && !rd_rdy[p];
        hold_dat[p] = rd_dat[p];
        if (hold_q[p]) begin
            holds[p] = holds[p] + 1;
        end
        if (mvld[p] && rd_rdy[p]) begin
            if (exp_q[p].size() == 0) begin
                errors = errors + 1;
                $display("Read handshake on pair %0d with no word written", p);
            end else begin
                front = exp_q[p].pop_front();
                compare($sformatf("rd_dat_o[%0d]", p), rd_dat[p], front);
                popped[p] = popped[p] + 1;
            end
        end
        if (wr_vld[p] && exp_rdy) begin
            masked = wr_dat[p];
            for (int k = 0; k < 2; k++) begin
                if (k >= par_p[p]) begin
                    masked[k] = '0;
                end
            end
            exp_q[p].push_back(masked);
            wcnt[p] = wcnt[p] + 1;
        end
        if (exp_issue) begin
            rcnt[p] = rcnt[p] + 1;
            mvld[p] = 1'b1;
        end else if (rd_rdy[p]) begin
            mvld[p] = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (mon_on) begin
            step_pair(0);
            step_pair(1);
        end
    end

    // One cycle of random traffic with an optional read stall on pair 0
    task automatic drive_cycle(input logic stall_rd0);
        @(posedge clk);
        #1;
        for (int p = 0; p < 2; p++) begin
            wr_vld[p]    = ($urandom % 4) != 0;
            wr_dat[p][0] = glb_pkg::word_t'($urandom);
            wr_dat[p][1] = glb_pkg::word_t'($urandom);
            rd_rdy[p]    = ($urandom % 4) != 0;
        end
        if (stall_rd0) begin
            wr_vld[0] = 1'b1;
            rd_rdy[0] = 1'b0;
        end
    endtask

    function automatic logic all_done();
        logic done;
        done = 1'b1;
        for (int p = 0; p < 2; p++) begin
            if (wcnt[p] != num_p[p] || rcnt[p] != num_p[p] || mvld[p] || exp_q[p].size() != 0) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        void'($urandom(32'h9a0913ba));
        clk = 1'b0;
        rst_n = 1'b0;
        cfg_vld = '0;
        wr_vld = '0;
        rd_rdy = '0;
        mon_on = 1'b0;
        errors = 0;
        checks = 0;
        cycle = 0;
        err_start = 0;
        num_p = '{NUM0, NUM1};
        par_p = '{PAR0, PAR1};
        cap_p = '{CAP0, CAP1};
        for (int p = 0; p < 2; p++) begin
            wr_dat[p] = '0;
            wcnt[p] = 0;
            rcnt[p] = 0;
            popped[p] = 0;
            fill_max[p] = 0;
            holds[p] = 0;
            mvld[p] = 1'b0;
            hold_q[p] = 1'b0;
            hold_dat[p] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            cfg[i] = '0;
        end

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        compare("cfg_rdy_o", cfg_rdy, 4'hf);
        compare("wr_rdy_o", wr_rdy, 2'b00);
        compare("rd_vld_o", rd_vld, 2'b00);
        report_test(1, "reset state");

        // Write ports 0..1 then read ports 0..1
        @(posedge clk);
        #1;
        cfg[0] = '{bank_flag: 8'h0f, num: NUM0, par: PAR0};
        cfg[2] = '{bank_flag: 8'h0f, num: NUM0, par: PAR0};
        cfg[1] = '{bank_flag: 8'hf0, num: NUM1, par: PAR1};
        cfg[3] = '{bank_flag: 8'hf0, num: NUM1, par: PAR1};
        cfg_vld = 4'hf;
        @(posedge clk);
        #1;
        cfg_vld = '0;
        @(negedge clk);
        compare("cfg_rdy_o", cfg_rdy, 4'h0);
        for (int p = 0; p < 2; p++) begin
            compare($sformatf("wr_addr_o[%0d]", p), wr_addr[p], 0);
            compare($sformatf("rd_addr_o[%0d]", p), rd_addr[p], 0);
        end
        report_test(2, "configuration");
        // Model starts from the next falling edge
        @(posedge clk);
        mon_on = 1'b1;

        repeat (40) drive_cycle(1'b0);
        report_test(3, "random traffic");

        repeat (40) drive_cycle(1'b1);
        compare("fill_max[0]", fill_max[0], CAP0);
        report_test(4, "full under back-pressure");
        compare("hold_cycles_seen", holds[0] > 0, 1'b1);
        report_test(5, "output hold");

        while (!all_done()) begin
            drive_cycle(1'b0);
        end
        // Keep pushing after the count is reached
        repeat (20) begin
            @(posedge clk);
            #1;
            wr_vld = 2'b11;
            rd_rdy = 2'b11;
        end
        @(negedge clk);
        #1;
        for (int p = 0; p < 2; p++) begin
            compare($sformatf("wr_rdy_o_end[%0d]", p), wr_rdy[p], 1'b0);
            compare($sformatf("read_words[%0d]", p), popped[p], num_p[p]);
        end
        report_test(6, "transfer count");

        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/glb_top.sv ====
// ==================================================
// Global buffer top level
// Write ports, read ports, bank arbiters and banks
// ==================================================

`timescale 1ns/1ns

module glb_top #(
    parameter int NUM_WRPORT = 2,
    parameter int NUM_RDPORT = 2
) (
    input  logic                               clk,
    input  logic                               rst_n,
    // Config, write ports first then read ports
    input  logic [NUM_WRPORT+NUM_RDPORT-1:0]   cfg_vld_i,
    input  glb_pkg::port_cfg_t                 cfg_i [NUM_WRPORT+NUM_RDPORT],
    output logic [NUM_WRPORT+NUM_RDPORT-1:0]   cfg_rdy_o,
    input  logic [NUM_WRPORT-1:0]              wr_vld_i,
    input  glb_pkg::lanes_t                    wr_dat_i [NUM_WRPORT],
    output logic [NUM_WRPORT-1:0]              wr_rdy_o,
    output glb_pkg::addr_t                     wr_addr_o [NUM_WRPORT],
    output logic [NUM_RDPORT-1:0]              rd_vld_o,
    output glb_pkg::lanes_t                    rd_dat_o [NUM_RDPORT],
    input  logic [NUM_RDPORT-1:0]              rd_rdy_i,
    output glb_pkg::addr_t                     rd_addr_o [NUM_RDPORT]
);

    localparam int WR_IDX_W = $clog2(NUM_WRPORT > 1 ? NUM_WRPORT : 2);
    localparam int RD_IDX_W = $clog2(NUM_RDPORT > 1 ? NUM_RDPORT : 2);

    glb_pkg::bank_mask_t wr_flag        [NUM_WRPORT];
    glb_pkg::bank_mask_t rd_flag        [NUM_RDPORT];
    glb_pkg::bank_idx_t  wr_cur_bank    [NUM_WRPORT];
    glb_pkg::bank_idx_t  rd_cur_bank    [NUM_RDPORT];
    glb_pkg::addr_t      wr_partner     [NUM_WRPORT];
    glb_pkg::addr_t      rd_partner     [NUM_RDPORT];
    glb_pkg::bank_wr_t   wr_req         [NUM_WRPORT][glb_pkg::NUM_BANK];
    glb_pkg::bank_rd_t   rd_req         [NUM_RDPORT][glb_pkg::NUM_BANK];
    glb_pkg::word_t      bank_dat       [glb_pkg::NUM_BANK];
    logic [WR_IDX_W-1:0] wr_owner       [glb_pkg::NUM_BANK];
    logic [RD_IDX_W-1:0] rd_owner       [glb_pkg::NUM_BANK];

    // ==================================================
    // Write ports
    // ==================================================
    for (genvar p = 0; p < NUM_WRPORT; p++) begin : g_wr
        assign wr_flag[p]    = cfg_i[p].bank_flag;
        // Partner is the reader owning this port's current bank
        assign wr_partner[p] = rd_addr_o[rd_owner[wr_cur_bank[p]]];

        glb_wr_port u_wr_port (
            .clk               (clk),
            .rst_n             (rst_n),
            .cfg_vld_i         (cfg_vld_i[p]),
            .cfg_i             (cfg_i[p]),
            .cfg_rdy_o         (cfg_rdy_o[p]),
            .wr_vld_i          (wr_vld_i[p]),
            .wr_dat_i          (wr_dat_i[p]),
            .wr_rdy_o          (wr_rdy_o[p]),
            .partner_rd_addr_i (wr_partner[p]),
            .addr_o            (wr_addr_o[p]),
            .cur_bank_o        (wr_cur_bank[p]),
            .wr_req_o          (wr_req[p])
        );
    end

    // ==================================================
    // Read ports
    // ==================================================
    for (genvar p = 0; p < NUM_RDPORT; p++) begin : g_rd
        assign rd_flag[p]    = cfg_i[NUM_WRPORT+p].bank_flag;
        assign rd_partner[p] = wr_addr_o[wr_owner[rd_cur_bank[p]]];

        glb_rd_port u_rd_port (
            .clk               (clk),
            .rst_n             (rst_n),
            .cfg_vld_i         (cfg_vld_i[NUM_WRPORT+p]),
            .cfg_i             (cfg_i[NUM_WRPORT+p]),
            .cfg_rdy_o         (cfg_rdy_o[NUM_WRPORT+p]),
            .rd_vld_o          (rd_vld_o[p]),
            .rd_dat_o          (rd_dat_o[p]),
            .rd_rdy_i          (rd_rdy_i[p]),
            .partner_wr_addr_i (rd_partner[p]),
            .addr_o            (rd_addr_o[p]),
            .cur_bank_o        (rd_cur_bank[p]),
            .rd_req_o          (rd_req[p]),
            .bank_dat_i        (bank_dat)
        );
    end

    // ==================================================
    // Banks with their arbiters
    // ==================================================
    for (genvar b = 0; b < glb_pkg::NUM_BANK; b++) begin : g_bank
        glb_pkg::bank_wr_t wr_col [NUM_WRPORT];
        glb_pkg::bank_rd_t rd_col [NUM_RDPORT];
        glb_pkg::bank_wr_t bank_wr;
        glb_pkg::bank_rd_t bank_rd;

        for (genvar p = 0; p < NUM_WRPORT; p++) begin : g_wr_col
            assign wr_col[p] = wr_req[p][b];
        end
        for (genvar p = 0; p < NUM_RDPORT; p++) begin : g_rd_col
            assign rd_col[p] = rd_req[p][b];
        end

        glb_bank_arb #(
            .NUM_WRPORT (NUM_WRPORT),
            .NUM_RDPORT (NUM_RDPORT),
            .BANK_ID    (b)
        ) u_arb (
            .wr_flag_i  (wr_flag),
            .rd_flag_i  (rd_flag),
            .wr_req_i   (wr_col),
            .rd_req_i   (rd_col),
            .wr_owner_o (wr_owner[b]),
            .rd_owner_o (rd_owner[b]),
            .bank_wr_o  (bank_wr),
            .bank_rd_o  (bank_rd)
        );

        glb_bank u_bank (
            .clk      (clk),
            .wr_i     (bank_wr),
            .rd_i     (bank_rd),
            .rd_dat_o (bank_dat[b])
        );
    end

endmodule

// ==== verilog/glb_rd_port.sv ====
// ==================================================
// Read port
// Address counter, empty check, issue and lane gather
// ==================================================

`timescale 1ns/1ns

module glb_rd_port (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_vld_i,
    input  glb_pkg::port_cfg_t  cfg_i,
    output logic                cfg_rdy_o,
    output logic                rd_vld_o,
    output glb_pkg::lanes_t     rd_dat_o,
    input  logic                rd_rdy_i,
    input  glb_pkg::addr_t      partner_wr_addr_i,
    output glb_pkg::addr_t      addr_o,
    output glb_pkg::bank_idx_t  cur_bank_o,
    output glb_pkg::bank_rd_t   rd_req_o [glb_pkg::NUM_BANK],
    input  glb_pkg::word_t      bank_dat_i [glb_pkg::NUM_BANK]
);

    glb_pkg::bank_mask_t hit;
    glb_pkg::row_t       row;
    glb_pkg::bank_idx_t  iss_bank_q;
    glb_pkg::par_t       iss_par_q;
    logic                alloc;
    logic                issue;

    glb_port_map u_map (
        .cfg_i      (cfg_i),
        .addr_i     (addr_o),
        .capacity_o (),
        .cur_bank_o (cur_bank_o),
        .hit_o      (hit),
        .row_o      (row)
    );

    assign alloc = |cfg_i.bank_flag;

    // Not empty, and the output slot is free or draining this cycle
    assign issue = alloc && (addr_o < cfg_i.num) && (addr_o < partner_wr_addr_i) &&
                   (!rd_vld_o || rd_rdy_i);

    always_comb begin
        for (int b = 0; b < glb_pkg::NUM_BANK; b++) begin
            rd_req_o[b].en  = issue && hit[b];
            rd_req_o[b].row = row;
        end
    end

    // ==================================================
    // Counter, valid flag and issue record
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_o     <= '0;
            cfg_rdy_o  <= 1'b1;
            rd_vld_o   <= 1'b0;
            iss_bank_q <= '0;
            iss_par_q  <= '0;
        end else if (cfg_vld_i) begin
            addr_o    <= '0;
            cfg_rdy_o <= 1'b0;
            rd_vld_o  <= 1'b0;
        end else begin
            if (issue) begin
                addr_o     <= addr_o + 1'b1;
                rd_vld_o   <= 1'b1;
                iss_bank_q <= cur_bank_o;
                iss_par_q  <= cfg_i.par;
            end else if (rd_rdy_i) begin
                rd_vld_o <= 1'b0;
            end
        end
    end

    // Banks hold their read data, so the lanes stay stable under back-pressure
    always_comb begin
        int bank;
        for (int k = 0; k < glb_pkg::MAXPAR; k++) begin
            bank = int'(iss_bank_q) + k;
            if (k < int'(iss_par_q) && bank < glb_pkg::NUM_BANK) begin
                rd_dat_o[k] = bank_dat_i[bank];
            end else begin
                rd_dat_o[k] = '0;
            end
        end
    end

endmodule

// ==== verilog/glb_wr_port.sv ====
// ==================================================
// Write port
// Address counter, full and count check, lane placement
// ==================================================

`timescale 1ns/1ns

module glb_wr_port (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_vld_i,
    input  glb_pkg::port_cfg_t  cfg_i,
    output logic                cfg_rdy_o,
    input  logic                wr_vld_i,
    input  glb_pkg::lanes_t     wr_dat_i,
    output logic                wr_rdy_o,
    input  glb_pkg::addr_t      partner_rd_addr_i,
    output glb_pkg::addr_t      addr_o,
    output glb_pkg::bank_idx_t  cur_bank_o,
    output glb_pkg::bank_wr_t   wr_req_o [glb_pkg::NUM_BANK]
);

    glb_pkg::addr_t      capacity;
    glb_pkg::bank_mask_t hit;
    glb_pkg::row_t       row;
    glb_pkg::addr_t      fill;
    logic                alloc;
    logic                hs;

    glb_port_map u_map (
        .cfg_i      (cfg_i),
        .addr_i     (addr_o),
        .capacity_o (capacity),
        .cur_bank_o (cur_bank_o),
        .hit_o      (hit),
        .row_o      (row)
    );

    assign alloc = |cfg_i.bank_flag;
    // Unread words still held for the partner
    assign fill  = addr_o - partner_rd_addr_i;

    assign wr_rdy_o = alloc && (addr_o < cfg_i.num) && (fill < capacity);
    assign hs       = wr_vld_i && wr_rdy_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_o    <= '0;
            cfg_rdy_o <= 1'b1;
        end else begin
            if (cfg_vld_i) begin
                addr_o    <= '0;
                cfg_rdy_o <= 1'b0;
            end else if (hs) begin
                addr_o <= addr_o + 1'b1;
            end
        end
    end

    // Lane k lands on current bank + k
    always_comb begin
        int lane;
        for (int b = 0; b < glb_pkg::NUM_BANK; b++) begin
            lane            = b - int'(cur_bank_o);
            wr_req_o[b].en  = hs && hit[b];
            wr_req_o[b].row = row;
            if (lane >= 0 && lane < glb_pkg::MAXPAR) begin
                wr_req_o[b].dat = wr_dat_i[lane];
            end else begin
                wr_req_o[b].dat = '0;
            end
        end
    end

endmodule

// ==== verilog/glb_bank_arb.sv ====
// ==================================================
// Per-bank owner selection
// Lowest flagged write and read port own the bank
// ==================================================

`timescale 1ns/1ns

module glb_bank_arb #(
    parameter int NUM_WRPORT = 2,
    parameter int NUM_RDPORT = 2,
    parameter int BANK_ID    = 0
) (
    input  glb_pkg::bank_mask_t wr_flag_i [NUM_WRPORT],
    input  glb_pkg::bank_mask_t rd_flag_i [NUM_RDPORT],
    input  glb_pkg::bank_wr_t   wr_req_i  [NUM_WRPORT],
    input  glb_pkg::bank_rd_t   rd_req_i  [NUM_RDPORT],
    output logic [$clog2(NUM_WRPORT > 1 ? NUM_WRPORT : 2)-1:0] wr_owner_o,
    output logic [$clog2(NUM_RDPORT > 1 ? NUM_RDPORT : 2)-1:0] rd_owner_o,
    output glb_pkg::bank_wr_t   bank_wr_o,
    output glb_pkg::bank_rd_t   bank_rd_o
);

    localparam int WR_IDX_W = $clog2(NUM_WRPORT > 1 ? NUM_WRPORT : 2);
    localparam int RD_IDX_W = $clog2(NUM_RDPORT > 1 ? NUM_RDPORT : 2);

    logic wr_found;
    logic rd_found;

    // ==================================================
    // Write owner
    // ==================================================
    always_comb begin
        wr_owner_o = '0;
        wr_found   = 1'b0;
        for (int p = 0; p < NUM_WRPORT; p++) begin
            if (!wr_found && wr_flag_i[p][BANK_ID]) begin
                wr_owner_o = WR_IDX_W'(p);
                wr_found   = 1'b1;
            end
        end
    end

    // Only the owner reaches the bank
    always_comb begin
        bank_wr_o = '0;
        if (wr_found) begin
            bank_wr_o = wr_req_i[wr_owner_o];
        end
    end

    // ==================================================
    // Read owner
    // ==================================================
    always_comb begin
        rd_owner_o = '0;
        rd_found   = 1'b0;
        for (int p = 0; p < NUM_RDPORT; p++) begin
            if (!rd_found && rd_flag_i[p][BANK_ID]) begin
                rd_owner_o = RD_IDX_W'(p);
                rd_found   = 1'b1;
            end
        end
    end

    always_comb begin
        bank_rd_o = '0;
        if (rd_found) begin
            bank_rd_o = rd_req_i[rd_owner_o];
        end
    end

endmodule

// ==== verilog/glb_port_map.sv ====
// ==================================================
// Port to bank mapping
// First bank, capacity, current bank, lane hit mask
// ==================================================

`timescale 1ns/1ns

module glb_port_map (
    input  glb_pkg::port_cfg_t  cfg_i,
    input  glb_pkg::addr_t      addr_i,
    output glb_pkg::addr_t      capacity_o,
    output glb_pkg::bank_idx_t  cur_bank_o,
    output glb_pkg::bank_mask_t hit_o,
    output glb_pkg::row_t       row_o
);

    glb_pkg::bank_idx_t first_bank;
    int unsigned        num_bank;
    int unsigned        par_eff;
    int unsigned        cap;
    int unsigned        cur;

    // Lowest flagged bank wins, count all flagged banks
    always_comb begin
        first_bank = '0;
        num_bank   = 0;
        for (int b = glb_pkg::NUM_BANK - 1; b >= 0; b--) begin
            if (cfg_i.bank_flag[b]) begin
                first_bank = glb_pkg::bank_idx_t'(b);
                num_bank   = num_bank + 1;
            end
        end
    end

    // Rows per lane group wrap around the capacity
    always_comb begin
        par_eff = (cfg_i.par == '0) ? 1 : cfg_i.par;
        cap     = (glb_pkg::SRAM_WORD * num_bank) / par_eff;
        if (cap == 0) begin
            cur = first_bank;
        end else begin
            cur = first_bank + ((addr_i % cap) / glb_pkg::SRAM_WORD) * par_eff;
        end
        // Lanes occupy consecutive banks from the current one
        for (int b = 0; b < glb_pkg::NUM_BANK; b++) begin
            hit_o[b] = (cap != 0) && (b >= cur) && (b < cur + par_eff);
        end
    end

    assign capacity_o = glb_pkg::addr_t'(cap);
    assign cur_bank_o = glb_pkg::bank_idx_t'(cur);
    assign row_o      = addr_i[glb_pkg::ROW_WIDTH-1:0];

endmodule

// ==== verilog/glb_bank.sv ====
// ==================================================
// One simple-dual-port memory bank
// Single write port, registered read port
// ==================================================

`timescale 1ns/1ns

module glb_bank (
    input  logic              clk,
    input  glb_pkg::bank_wr_t wr_i,
    input  glb_pkg::bank_rd_t rd_i,
    output glb_pkg::word_t    rd_dat_o
);

    glb_pkg::word_t mem [glb_pkg::SRAM_WORD];

    // Write side
    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            mem[wr_i.row] <= wr_i.dat;
        end
    end

    // Read side, output holds until the next read
    always_ff @(posedge clk) begin
        if (rd_i.en) begin
            rd_dat_o <= mem[rd_i.row];
        end
    end

endmodule

// ==== verilog/glb_pkg.sv ====
// ==================================================
// Global buffer shared definitions
// Sizes, vector types, configuration and bank access
// ==================================================

package glb_pkg;

    // ==================================================
    // Sizes
    // ==================================================
    localparam int NUM_BANK   = 8;
    localparam int SRAM_WORD  = 16;
    localparam int SRAM_WIDTH = 16;
    localparam int MAXPAR     = 2;
    localparam int ADDR_WIDTH = 10;

    localparam int ROW_WIDTH  = $clog2(SRAM_WORD);
    localparam int BANK_IDX_W = $clog2(NUM_BANK);
    // Holds 1 .. MAXPAR
    localparam int PAR_WIDTH  = $clog2(MAXPAR) + 1;

    // ==================================================
    // Vector types
    // ==================================================
    typedef logic [SRAM_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [ROW_WIDTH-1:0]  row_t;
    typedef logic [BANK_IDX_W-1:0] bank_idx_t;
    typedef logic [NUM_BANK-1:0]   bank_mask_t;
    typedef logic [PAR_WIDTH-1:0]  par_t;

    // Port data bus, lane 0 in the low word
    typedef word_t [MAXPAR-1:0] lanes_t;

    // ==================================================
    // Structs
    // ==================================================

    // Per-port settings loaded with the config strobe
    typedef struct packed {
        bank_mask_t bank_flag;
        addr_t      num;
        par_t       par;
    } port_cfg_t;

    // Write access into one bank
    typedef struct packed {
        logic  en;
        row_t  row;
        word_t dat;
    } bank_wr_t;

    // Read access into one bank
    typedef struct packed {
        logic en;
        row_t row;
    } bank_rd_t;

endpackage
